// ==== files.f ====
hdl/cipher_pkg.sv
hdl/control_pkg.sv
hdl/char_entry.sv
hdl/caesar_shifter.sv
hdl/cipher_sequencer.sv
hdl/cipher_datapath.sv
hdl/cipher_top.sv
tb/cipher_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cipher testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module cipher_top_tb -o cipher_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/cipher_sim)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Testbench passed" <<< "$sim_out"; then
	exit 0
fi
exit 1

// ==== tb/cipher_top_tb.sv ====
`timescale 1ns/1ps

module cipher_top_tb
	import cipher_pkg::*;
	import control_pkg::*;
;

	localparam int NUM_CHARS = 5;
	localparam int TEXT_W = NUM_CHARS * CHAR_W;
	localparam int NUM_ROWS = 9;
	localparam int NUM_RANDOM = 6;
	// Cycles to wait for done after go.
	localparam int RUN_TIMEOUT = 40;

	// One table row. The letters are shown with the view method before the run.
	typedef struct packed
	{
		logic [TEXT_W-1:0] letters;
		shift_t            shift;
		logic              decode;
		method_t           view;
		logic [TEXT_W-1:0] expected;
	} row_t;

	logic                  clock;
	logic                  resetn;
	char_t                 char_in;
	logic                  char_load;
	logic                  go;
	logic                  decode;
	shift_t                shift;
	method_t               method;
	char_t [NUM_CHARS-1:0] text_out;
	logic                  busy;
	logic                  done;

	row_t rows [NUM_ROWS];
	int   errors;
	bit   timed_out;

	cipher_top #(.NUM_CHARS(NUM_CHARS)) dut
	(
		.clock     (clock),
		.resetn    (resetn),
		.char_in   (char_in),
		.char_load (char_load),
		.go        (go),
		.decode    (decode),
		.shift     (shift),
		.method    (method),
		.text_out  (text_out),
		.busy      (busy),
		.done      (done)
	);

	// 8 ns clock.
	always #4 clock = ~clock;

	// Next edge, then 1 ns for inputs and samples.
	task automatic step();
		@(posedge clock);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERROR: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// One letter by the cipher rule; blank stays blank.
	function automatic int cipher_letter(input int c, input int s, input bit dec);
		int v;
		if (c == 0)
		begin
			return 0;
		end
		v = dec ? (c - 1 - s) : (c - 1 + s);
		v = v % 26;
		if (v < 0)
		begin
			v = v + 26;
		end
		return v + 1;
	endfunction

	// Whole word with the first letter on top.
	function automatic logic [TEXT_W-1:0] cipher_word(input logic [TEXT_W-1:0] w,
		input int s, input bit dec);
		logic [TEXT_W-1:0] r;
		r = '0;
		for (int i = 0; i < NUM_CHARS; i++)
		begin
			r[TEXT_W-1-CHAR_W*i -: CHAR_W] =
				CHAR_W'(cipher_letter(int'(w[TEXT_W-1-CHAR_W*i -: CHAR_W]), s, dec));
		end
		return r;
	endfunction

	// Lower-case text to letter codes; a space is a blank.
	function automatic logic [TEXT_W-1:0] text_word(input string s);
		logic [TEXT_W-1:0] w;
		byte ch;
		w = '0;
		for (int i = 0; i < NUM_CHARS; i++)
		begin
			ch = s[i];
			w = w << CHAR_W;
			// Code 1 is ASCII 'a'.
			if (ch != " ")
			begin
				w[CHAR_W-1:0] = CHAR_W'(ch - 8'h60);
			end
		end
		return w;
	endfunction

	task automatic set_row(input int idx, input string plain, input int s, input bit dec,
		input method_t view, input string exp);
		rows[idx].letters  = text_word(plain);
		rows[idx].shift    = shift_t'(s);
		rows[idx].decode   = dec;
		rows[idx].view     = view;
		rows[idx].expected = text_word(exp);
	endtask

	task automatic load_char(input char_t c);
		char_in   = c;
		char_load = 1'b1;
		step();
		char_load = 1'b0;
	endtask

	task automatic load_word(input logic [TEXT_W-1:0] w);
		for (int i = 0; i < NUM_CHARS; i++)
		begin
			load_char(w[TEXT_W-1-CHAR_W*i -: CHAR_W]);
		end
	endtask

	// Go, then follow busy and done cycle by cycle.
	// With disturb set, loads and a second go land in the middle of the run.
	task automatic run_cipher(input logic [TEXT_W-1:0] expected, input bit disturb);
		int k;
		bit seen;
		method = METHOD_CAESAR;
		go     = 1'b1;
		step();
		go   = 1'b0;
		k    = 1;
		seen = 1'b0;
		while (!seen && k <= RUN_TIMEOUT)
		begin
			check_value("busy", 32'(busy), 32'(k <= 16));
			check_value("done", 32'(done), 32'(k == 17));
			if (done)
			begin
				seen = 1'b1;
			end
			else
			begin
				// Busy is high here, so this go must be dropped.
				go        = disturb && (k == 5);
				char_in   = char_t'(17);
				char_load = disturb && (k >= 3) && (k <= 7);
				step();
				k++;
			end
		end
		go        = 1'b0;
		char_load = 1'b0;
		if (seen)
		begin
			check_value("text_out", 32'(text_out), 32'(expected));
		end
		else
		begin
			$display("Timeout: done did not rise within %0d cycles of go", RUN_TIMEOUT);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	initial
	begin
		logic [TEXT_W-1:0] word;
		logic [TEXT_W-1:0] enc;
		int s;

		void'($urandom(32'h29ca));
		errors    = 0;
		timed_out = 1'b0;
		clock     = 1'b0;
		resetn    = 1'b0;
		char_in   = CHAR_BLANK;
		char_load = 1'b0;
		go        = 1'b0;
		decode    = 1'b0;
		shift     = '0;
		method    = METHOD_PLAIN;

		// Wrap past z, shifts of 26 and up, blanks, decode back.
		set_row(0, "hello", 3, 1'b0, METHOD_PLAIN, "khoor");
		set_row(1, "xyzab", 5, 1'b0, METHOD_VIGENERE, "cdefg");
		set_row(2, "cat  ", 26, 1'b0, METHOD_PLAIN_ALT, "cat  ");
		set_row(3, "a zmn", 31, 1'b0, METHOD_PLAIN, "f ers");
		set_row(4, "khoor", 3, 1'b1, METHOD_VIGENERE, "hello");
		set_row(5, "abcz ", 5, 1'b1, METHOD_PLAIN_ALT, "vwxu ");
		set_row(6, "adzbc", 29, 1'b1, METHOD_PLAIN, "xawyz");
		set_row(7, "zyxwv", 0, 1'b0, METHOD_VIGENERE, "zyxwv");
		set_row(8, "za ei", 26, 1'b1, METHOD_PLAIN_ALT, "za ei");

		repeat (16) step();
		resetn = 1'b1;
		step();

		// Blank buffer and blank result out of reset.
		check_value("text_out", 32'(text_out), 32'h0);
		check_value("busy", 32'(busy), 32'h0);
		check_value("done", 32'(done), 32'h0);
		method = METHOD_CAESAR;
		step();
		check_value("text_out", 32'(text_out), 32'h0);

		for (int i = 0; i < NUM_ROWS && !timed_out; i++)
		begin
			load_word(rows[i].letters);
			method = rows[i].view;
			step();
			check_value("text_out", 32'(text_out), 32'(rows[i].letters));
			check_value("table row",
				32'(cipher_word(rows[i].letters, rows[i].shift, rows[i].decode)),
				32'(rows[i].expected));
			shift  = rows[i].shift;
			decode = rows[i].decode;
			run_cipher(rows[i].expected, 1'b0);
		end

		// Random words, encoded and then decoded back.
		for (int i = 0; i < NUM_RANDOM && !timed_out; i++)
		begin
			word = '0;
			for (int j = 0; j < NUM_CHARS; j++)
			begin
				word = {word[TEXT_W-CHAR_W-1:0], CHAR_W'($urandom % 27)};
			end
			s   = int'($urandom % 32);
			enc = cipher_word(word, s, 1'b0);
			load_word(word);
			shift  = shift_t'(s);
			decode = 1'b0;
			run_cipher(enc, 1'b0);
			if (!timed_out)
			begin
				load_word(enc);
				decode = 1'b1;
				run_cipher(word, 1'b0);
			end
		end

		// Loads and go during a run leave its result alone.
		if (!timed_out)
		begin
			word = text_word("quack");
			load_word(word);
			shift  = shift_t'(7);
			decode = 1'b0;
			run_cipher(cipher_word(word, 7, 1'b0), 1'b1);
			method = METHOD_PLAIN;
			step();
			check_value("text_out", 32'(text_out), 32'(text_word("qqqqq")));
		end

		// Sixth load lands in the first slot again.
		if (!timed_out)
		begin
			load_word(text_word("abcde"));
			load_char(char_t'(26));
			step();
			check_value("text_out", 32'(text_out), 32'(text_word("zbcde")));
		end

		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== hdl/cipher_top.sv ====
`timescale 1ns/1ps

module cipher_top
	import cipher_pkg::*;
	import control_pkg::*;
#(
	parameter int NUM_CHARS = 5,
	localparam int SLOT_W = $clog2(NUM_CHARS)
)
(
	input  logic                  clock,
	input  logic                  resetn,
	input  char_t                 char_in,
	input  logic                  char_load,
	input  logic                  go,
	input  logic                  decode,
	input  shift_t                shift,
	input  method_t               method,
	output char_t [NUM_CHARS-1:0] text_out,
	output logic                  busy,
	output logic                  done
);

	// Buffer contents as typed.
	char_t [NUM_CHARS-1:0] plain_text;

	// Sequencer strobes.
	logic              snap;
	logic              select;
	logic              write;
	logic [SLOT_W-1:0] slot;

	char_entry #(.NUM_CHARS(NUM_CHARS)) u_entry
	(
		.clock      (clock),
		.resetn     (resetn),
		.char_in    (char_in),
		.char_load  (char_load),
		.plain_text (plain_text)
	);

	cipher_sequencer #(.NUM_CHARS(NUM_CHARS)) u_seq
	(
		.clock  (clock),
		.resetn (resetn),
		.go     (go),
		.snap   (snap),
		.select (select),
		.write  (write),
		.slot   (slot),
		.busy   (busy),
		.done   (done)
	);

	cipher_datapath #(.NUM_CHARS(NUM_CHARS)) u_datapath
	(
		.clock      (clock),
		.resetn     (resetn),
		.plain_text (plain_text),
		.shift      (shift),
		.decode     (decode),
		.method     (method),
		.snap       (snap),
		.select     (select),
		.write      (write),
		.slot       (slot),
		.text_out   (text_out)
	);

endmodule

// ==== hdl/cipher_datapath.sv ====
`timescale 1ns/1ps

module cipher_datapath
	import cipher_pkg::*;
	import control_pkg::*;
#(
	parameter int NUM_CHARS = 5,
	localparam int SLOT_W = $clog2(NUM_CHARS)
)
(
	input  logic                  clock,
	input  logic                  resetn,
	input  char_t [NUM_CHARS-1:0] plain_text,
	input  shift_t                shift,
	input  logic                  decode,
	input  method_t               method,
	input  logic                  snap,
	input  logic                  select,
	input  logic                  write,
	input  logic [SLOT_W-1:0]     slot,
	output char_t [NUM_CHARS-1:0] text_out
);

	// Slot 0 sits in the most significant letter.
	localparam logic [SLOT_W-1:0] TOP_POS = SLOT_W'(NUM_CHARS - 1);

	// Snapshot taken at the start of a run.
	char_t [NUM_CHARS-1:0] snap_text;
	shift_t                snap_shift;
	logic                  snap_decode;

	// Letter on its way into the shifter.
	char_t cur_char;

	// Shifter output.
	// Valid one cycle after select.
	char_t shifted;

	// Cipher result.
	char_t [NUM_CHARS-1:0] result;

	// Position of the current slot in the packed text.
	logic [SLOT_W-1:0] pos;

	assign pos = TOP_POS - slot;

	// Snapshot and current letter.
	always_ff @(posedge clock)
	begin
		if (snap)
		begin
			snap_text   <= plain_text;
			snap_shift  <= shift;
			snap_decode <= decode;
		end
		if (select)
		begin
			cur_char <= snap_text[pos];
		end
	end

	// Result letters.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			result <= {NUM_CHARS{CHAR_BLANK}};
		end
		else if (write)
		begin
			result[pos] <= shifted;
		end
	end

	caesar_shifter u_shifter
	(
		.clock    (clock),
		.cur_char (cur_char),
		.shift    (snap_shift),
		.decode   (snap_decode),
		.shifted  (shifted)
	);

	// Output select.
	// Every method but Caesar shows the buffer as typed.
	always_comb
	begin
		case (method)
			METHOD_CAESAR: text_out = result;
			default:       text_out = plain_text;
		endcase
	end

endmodule

// ==== hdl/cipher_sequencer.sv ====
`timescale 1ns/1ps

module cipher_sequencer
	import cipher_pkg::*;
	import control_pkg::*;
#(
	parameter int NUM_CHARS = 5,
	localparam int SLOT_W = $clog2(NUM_CHARS)
)
(
	input  logic              clock,
	input  logic              resetn,
	input  logic              go,
	output logic              snap,
	output logic              select,
	output logic              write,
	output logic [SLOT_W-1:0] slot,
	output logic              busy,
	output logic              done
);

	localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_CHARS - 1);

	seq_state_t state;
	seq_state_t next_state;

	// Next state.
	always_comb
	begin
		next_state = state;
		case (state)
			SEQ_IDLE:
			begin
				if (go)
				begin
					next_state = SEQ_LOAD;
				end
			end
			SEQ_LOAD:   next_state = SEQ_SELECT;
			SEQ_SELECT: next_state = SEQ_SHIFT;
			SEQ_SHIFT:  next_state = SEQ_WRITE;
			SEQ_WRITE:
			begin
				if (slot == LAST_SLOT)
				begin
					next_state = SEQ_DONE;
				end
				else
				begin
					next_state = SEQ_SELECT;
				end
			end
			SEQ_DONE:
			begin
				// Busy is already low here, so a go starts the next run.
				if (go)
				begin
					next_state = SEQ_LOAD;
				end
				else
				begin
					next_state = SEQ_IDLE;
				end
			end
			default:    next_state = SEQ_IDLE;
		endcase
	end

	// State and slot counter.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			state <= SEQ_IDLE;
			slot  <= '0;
		end
		else
		begin
			state <= next_state;
			// Slot moves on after each write.
			if (state == SEQ_LOAD || (state == SEQ_WRITE && slot == LAST_SLOT))
			begin
				slot <= '0;
			end
			else if (state == SEQ_WRITE)
			begin
				slot <= slot + 1'b1;
			end
		end
	end

	// Strobes to the datapath.
	assign snap   = (state == SEQ_LOAD);
	assign select = (state == SEQ_SELECT);
	assign write  = (state == SEQ_WRITE);

	// Status.
	assign busy = (state != SEQ_IDLE) && (state != SEQ_DONE);
	assign done = (state == SEQ_DONE);

	a_done_pulse: assert property (@(posedge clock) disable iff (!resetn)
		done |=> !done);

	a_slot_range: assert property (@(posedge clock) disable iff (!resetn)
		busy |-> (slot <= LAST_SLOT));

endmodule

// ==== hdl/caesar_shifter.sv ====
`timescale 1ns/1ps

module caesar_shifter
	import cipher_pkg::*;
(
	input  logic   clock,
	input  char_t  cur_char,
	input  shift_t shift,
	input  logic   decode,
	output char_t  shifted
);

	// Alphabet size at the internal width.
	localparam logic [5:0] AB = 6'(ALPHABET_SIZE);

	// Zero-based letter index and reduced shift.
	// Both run from 0 to 25.
	logic [5:0] c_idx;
	logic [5:0] s_mod;

	// Zero-based index after the shift.
	logic [5:0] out_idx;

	always_comb
	begin
		// Shifts of 26 and up wrap once.
		s_mod = {1'b0, shift};
		if (s_mod >= AB)
		begin
			s_mod = s_mod - AB;
		end

		// Out-of-range codes fold back into the alphabet.
		c_idx = {1'b0, cur_char} - 6'd1;
		if (c_idx >= AB)
		begin
			c_idx = c_idx - AB;
		end

		if (decode)
		begin
			// Borrow a full alphabet when the difference goes negative.
			if (c_idx < s_mod)
			begin
				out_idx = c_idx + AB - s_mod;
			end
			else
			begin
				out_idx = c_idx - s_mod;
			end
		end
		else
		begin
			// Sum is at most 50, so one wrap is enough.
			out_idx = c_idx + s_mod;
			if (out_idx >= AB)
			begin
				out_idx = out_idx - AB;
			end
		end
	end

	// One cycle of latency.
	always_ff @(posedge clock)
	begin
		if (cur_char == CHAR_BLANK)
		begin
			shifted <= CHAR_BLANK;
		end
		else
		begin
			shifted <= char_t'(out_idx + 6'd1);
		end
	end

	// A known letter in gives a blank or a real letter one cycle later.
	a_shifted_range: assert property (@(posedge clock)
		!$isunknown(cur_char) |=> (shifted <= char_t'(ALPHABET_SIZE)));

endmodule

// ==== hdl/char_entry.sv ====
`timescale 1ns/1ps

module char_entry
	import cipher_pkg::*;
#(
	parameter int NUM_CHARS = 5,
	localparam int SLOT_W = $clog2(NUM_CHARS)
)
(
	input  logic                    clock,
	input  logic                    resetn,
	input  char_t                   char_in,
	input  logic                    char_load,
	output char_t [NUM_CHARS-1:0]   plain_text
);

	// Letter slots.
	// Slot 0 holds the first letter.
	char_t slot_q [NUM_CHARS];

	// Slot that the next load writes.
	logic [SLOT_W-1:0] wr_idx;

	// Last valid slot index.
	localparam logic [SLOT_W-1:0] LAST_IDX = SLOT_W'(NUM_CHARS - 1);

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < NUM_CHARS; i++)
			begin
				slot_q[i] <= CHAR_BLANK;
			end
			wr_idx <= '0;
		end
		else if (char_load)
		begin
			slot_q[wr_idx] <= char_in;
			// Wrap back to the first slot after the last one.
			if (wr_idx == LAST_IDX)
			begin
				wr_idx <= '0;
			end
			else
			begin
				wr_idx <= wr_idx + 1'b1;
			end
		end
	end

	// First letter goes to the most significant slot.
	always_comb
	begin
		for (int i = 0; i < NUM_CHARS; i++)
		begin
			plain_text[NUM_CHARS-1-i] = slot_q[i];
		end
	end

endmodule

// ==== hdl/control_pkg.sv ====
package control_pkg;

	// Display method.
	// The Vigenere code is reserved and shows the plain buffer.
	typedef enum logic [1:0]
	{
		METHOD_PLAIN     = 2'b00,
		METHOD_CAESAR    = 2'b01,
		METHOD_VIGENERE  = 2'b10,
		METHOD_PLAIN_ALT = 2'b11
	} method_t;

	// Sequencer states.
	// SELECT, SHIFT and WRITE repeat once per letter.
	typedef enum logic [2:0]
	{
		SEQ_IDLE,
		SEQ_LOAD,
		SEQ_SELECT,
		SEQ_SHIFT,
		SEQ_WRITE,
		SEQ_DONE
	} seq_state_t;

endpackage

// ==== hdl/cipher_pkg.sv ====
package cipher_pkg;

	// Width of one letter code.
	localparam int CHAR_W = 5;

	// Letters run from 1 for a to 26 for z.
	localparam int ALPHABET_SIZE = 26;

	// One letter code.
	typedef logic [CHAR_W-1:0] char_t;

	// Shift amount from 0 to 31.
	// Values of 26 and up wrap back around the alphabet.
	typedef logic [4:0] shift_t;

	// Code 0 is a blank.
	// It passes through the shifter untouched.
	localparam char_t CHAR_BLANK = char_t'(0);

endpackage
